// ==== source/exec_unit_dtypes.sv ====
package exec_unit_dtypes;

  // exchanged value and register number widths
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned LOG2_NUM_REG   = 4;

  // each statistics counter
  localparam int unsigned STAT_CNT_WIDTH = 8;

  typedef logic [LOG2_NUM_REG-1:0] type_exec_unit_addr;
  typedef logic [DATA_WIDTH-1:0]   type_exec_unit_data;

  // one slot entry as the read side sees it
  typedef struct packed {
    logic               has_been_read;
    type_exec_unit_data data;
  } type_xcache_data;

  // single-cycle strobes, one per resolved request
  typedef struct packed {
    logic write_ok;
    logic write_reject;
    logic read_hit;
    logic read_miss;
  } type_xbuf_event;

  // write_ok sits in the top byte, read_miss in the bottom byte
  typedef struct packed {
    logic [STAT_CNT_WIDTH-1:0] write_ok;
    logic [STAT_CNT_WIDTH-1:0] write_reject;
    logic [STAT_CNT_WIDTH-1:0] read_hit;
    logic [STAT_CNT_WIDTH-1:0] read_miss;
  } type_xbuf_stats;

endpackage

// ==== source/xbuf_axi_pkg.sv ====
package xbuf_axi_pkg;

  localparam int unsigned AXI_ADDR_WIDTH = 8;
  localparam int unsigned AXI_DATA_WIDTH = 32;

  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_SLVERR = 2'b10
  } axi_resp_e;

  // data registers live at 4*n below this, bit 6 picks the counters
  localparam logic [AXI_ADDR_WIDTH-1:0] STATS_ADDR = 8'h40;

  // master to slave
  typedef struct packed {
    logic                      awvalid;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      wvalid;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      bready;
    logic                      arvalid;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      rready;
  } axi_lite_req_t;

  // slave to master
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    axi_resp_e                 bresp;
    logic                      arready;
    logic                      rvalid;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    axi_resp_e                 rresp;
  } axi_lite_rsp_t;

  // true when the address selects the statistics register
  function automatic logic is_stats_addr(input logic [AXI_ADDR_WIDTH-1:0] addr);
    return (addr & STATS_ADDR) != '0;
  endfunction

endpackage

// ==== source/xbuf_tag_store.sv ====
`timescale 1ns/1ps

module xbuf_tag_store #(
  parameter int unsigned IDX_BITS = 2
) (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 ce_i,
  input  logic                                 we_i,
  input  exec_unit_dtypes::type_exec_unit_addr waddr_i,
  input  exec_unit_dtypes::type_exec_unit_addr raddr_i,
  input  exec_unit_dtypes::type_exec_unit_data wdata_i,
  output exec_unit_dtypes::type_exec_unit_data rdata_o,
  output logic                                 rhit_o
);
  import exec_unit_dtypes::*;

  localparam int unsigned NUM_SLOTS = 2**IDX_BITS;
  localparam int unsigned TAG_BITS  = LOG2_NUM_REG - IDX_BITS;

  type_exec_unit_data  data_mem [NUM_SLOTS];
  logic [TAG_BITS-1:0] tag_mem  [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] valid;

  logic [IDX_BITS-1:0] widx;
  logic [IDX_BITS-1:0] ridx;
  logic [TAG_BITS-1:0] wtag;
  logic [TAG_BITS-1:0] rtag;
  logic                wr_en;

  // low bits index the slot, the rest is kept as tag
  assign widx  = waddr_i[IDX_BITS-1:0];
  assign ridx  = raddr_i[IDX_BITS-1:0];
  assign wtag  = waddr_i[LOG2_NUM_REG-1:IDX_BITS];
  assign rtag  = raddr_i[LOG2_NUM_REG-1:IDX_BITS];
  assign wr_en = ce_i & we_i;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[widx] <= 1'b1;
    end
  end

  // read returns the old word when the same slot is written at this edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[widx] <= wdata_i;
      tag_mem[widx]  <= wtag;
    end
    if (ce_i) begin
      rdata_o <= data_mem[ridx];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rhit_o <= 1'b0;
    end else if (ce_i) begin
      rhit_o <= valid[ridx] && (tag_mem[ridx] == rtag);
    end
  end

endmodule

// ==== source/xbuf_slot.sv ====
`timescale 1ns/1ps

module xbuf_slot #(
  parameter int unsigned IDX_BITS = 2
) (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 we_i,
  input  exec_unit_dtypes::type_exec_unit_addr waddr_i,
  input  exec_unit_dtypes::type_exec_unit_data wdata_i,
  input  logic                                 re_i,
  input  exec_unit_dtypes::type_exec_unit_addr raddr_i,
  output logic                                 wready_o,
  output logic                                 rhit_o,
  output exec_unit_dtypes::type_exec_unit_data rdata_o,
  output exec_unit_dtypes::type_xbuf_event     event_o
);
  import exec_unit_dtypes::*;

  localparam int unsigned NUM_SLOTS = 2**IDX_BITS;

  logic [IDX_BITS-1:0]  widx;
  logic [IDX_BITS-1:0]  ridx;
  logic [IDX_BITS-1:0]  ridx_q;
  logic [NUM_SLOTS-1:0] has_been_read;

  logic               collision;
  logic               store_ce;
  logic               store_hit;
  type_exec_unit_data store_rdata;
  type_xcache_data    rd_entry;

  logic               re_q;
  logic               byp_q;
  logic               hbr_q;
  type_exec_unit_data byp_data_q;

  logic rd_hit_store;
  logic write_ok;

  assign widx = waddr_i[IDX_BITS-1:0];
  assign ridx = raddr_i[IDX_BITS-1:0];

  // same register on both sides skips the store and forwards the write
  assign collision = we_i & re_i & (waddr_i == raddr_i);
  assign store_ce  = ~collision & (we_i | re_i);

  // store word paired with the flag captured alongside the read strobe
  assign rd_entry.data          = store_rdata;
  assign rd_entry.has_been_read = hbr_q;

  assign rd_hit_store = re_q & ~byp_q & store_hit & ~rd_entry.has_been_read;

  // a hit resolving this cycle frees its slot for a write in the same cycle
  assign wready_o = collision | has_been_read[widx] | (rd_hit_store & (ridx_q == widx));
  assign write_ok = we_i & wready_o;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      has_been_read <= '1;
    end else begin
      if (rd_hit_store) begin
        has_been_read[ridx_q] <= 1'b1;
      end
      // a new write wins over the consume of an older entry
      if (write_ok & ~collision) begin
        has_been_read[widx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      re_q  <= 1'b0;
      byp_q <= 1'b0;
    end else begin
      re_q  <= re_i;
      byp_q <= collision;
    end
  end

  always_ff @(posedge clk) begin
    if (re_i) begin
      ridx_q <= ridx;
      hbr_q  <= has_been_read[ridx];
    end
    if (collision) begin
      byp_data_q <= wdata_i;
    end
  end

  xbuf_tag_store #(
    .IDX_BITS(IDX_BITS)
  ) u_tag_store (
    .clk     (clk),
    .reset_n (reset_n),
    .ce_i    (store_ce),
    .we_i    (write_ok),
    .waddr_i (waddr_i),
    .raddr_i (raddr_i),
    .wdata_i (wdata_i),
    .rdata_o (store_rdata),
    .rhit_o  (store_hit)
  );

  assign rhit_o  = byp_q | rd_hit_store;
  assign rdata_o = byp_q ? byp_data_q : rd_entry.data;

  assign event_o.write_ok     = write_ok;
  assign event_o.write_reject = we_i & ~wready_o;
  assign event_o.read_hit     = rhit_o;
  assign event_o.read_miss    = re_q & ~rhit_o;

endmodule

// ==== source/xbuf_stats.sv ====
`timescale 1ns/1ps

module xbuf_stats (
  input  logic                             clk,
  input  logic                             reset_n,
  input  exec_unit_dtypes::type_xbuf_event event_i,
  output exec_unit_dtypes::type_xbuf_stats stats_o
);
  import exec_unit_dtypes::*;

  type_xbuf_stats cnt_q;

  // counters stick at all ones
  function automatic logic [STAT_CNT_WIDTH-1:0] sat_inc(
    input logic [STAT_CNT_WIDTH-1:0] cnt,
    input logic                      inc
  );
    logic [STAT_CNT_WIDTH-1:0] next;
    next = cnt;
    if (inc && (cnt != '1)) begin
      next = cnt + 1'b1;
    end
    return next;
  endfunction

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q.write_ok     <= sat_inc(cnt_q.write_ok, event_i.write_ok);
      cnt_q.write_reject <= sat_inc(cnt_q.write_reject, event_i.write_reject);
      cnt_q.read_hit     <= sat_inc(cnt_q.read_hit, event_i.read_hit);
      cnt_q.read_miss    <= sat_inc(cnt_q.read_miss, event_i.read_miss);
    end
  end

  assign stats_o = cnt_q;

endmodule

// ==== source/xbuf_ctrl.sv ====
`timescale 1ns/1ps

module xbuf_ctrl (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  xbuf_axi_pkg::axi_lite_req_t          axi_req_i,
  output xbuf_axi_pkg::axi_lite_rsp_t          axi_rsp_o,
  output logic                                 slot_we_o,
  output exec_unit_dtypes::type_exec_unit_addr slot_waddr_o,
  output exec_unit_dtypes::type_exec_unit_data slot_wdata_o,
  output logic                                 slot_re_o,
  output exec_unit_dtypes::type_exec_unit_addr slot_raddr_o,
  input  logic                                 slot_wready_i,
  input  logic                                 slot_rhit_i,
  input  exec_unit_dtypes::type_exec_unit_data slot_rdata_i,
  input  exec_unit_dtypes::type_xbuf_stats     stats_i
);
  import exec_unit_dtypes::*;
  import xbuf_axi_pkg::*;

  // register number starts above the byte offset
  localparam int unsigned REG_LSB = 2;

  // idle takes a request, exec drives the slot, resp waits for the master
  typedef enum logic [1:0] {
    CH_IDLE,
    CH_EXEC,
    CH_RESP
  } ch_state_e;

  ch_state_e w_state;
  ch_state_e r_state;

  logic aw_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  axi_resp_e b_resp_q;

  logic                      r_from_slot_q;
  logic [AXI_DATA_WIDTH-1:0] r_data_q;
  axi_resp_e                 r_resp_q;
  logic [AXI_DATA_WIDTH-1:0] r_live_data;
  axi_resp_e                 r_live_resp;

  assign aw_hs = axi_req_i.awvalid & axi_req_i.wvalid & (w_state == CH_IDLE);
  assign b_hs  = axi_req_i.bready & (w_state == CH_RESP);
  assign ar_hs = axi_req_i.arvalid & (r_state == CH_IDLE);
  assign r_hs  = axi_req_i.rready & (r_state == CH_RESP);

  // write channel
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      w_state   <= CH_IDLE;
      slot_we_o <= 1'b0;
    end else begin
      slot_we_o <= 1'b0;
      case (w_state)
        CH_IDLE: begin
          if (aw_hs) begin
            w_state   <= CH_EXEC;
            slot_we_o <= !is_stats_addr(axi_req_i.awaddr);
          end
        end
        CH_EXEC: begin
          w_state <= CH_RESP;
        end
        CH_RESP: begin
          if (b_hs) begin
            w_state <= CH_IDLE;
          end
        end
        default: begin
          w_state <= CH_IDLE;
        end
      endcase
    end
  end

  // statistics register is read only, so a write there is refused
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      slot_waddr_o <= axi_req_i.awaddr[REG_LSB +: LOG2_NUM_REG];
      slot_wdata_o <= axi_req_i.wdata;
    end
    if (w_state == CH_EXEC) begin
      b_resp_q <= (slot_we_o && slot_wready_i) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  // read channel
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      r_state       <= CH_IDLE;
      slot_re_o     <= 1'b0;
      r_from_slot_q <= 1'b0;
    end else begin
      slot_re_o     <= 1'b0;
      r_from_slot_q <= 1'b0;
      case (r_state)
        CH_IDLE: begin
          if (ar_hs) begin
            r_state   <= CH_EXEC;
            slot_re_o <= !is_stats_addr(axi_req_i.araddr);
          end
        end
        CH_EXEC: begin
          r_state       <= CH_RESP;
          r_from_slot_q <= slot_re_o;
        end
        CH_RESP: begin
          if (r_hs) begin
            r_state <= CH_IDLE;
          end
        end
        default: begin
          r_state <= CH_IDLE;
        end
      endcase
    end
  end

  // slot result is only valid in the first response cycle
  assign r_live_data = slot_rhit_i ? slot_rdata_i : '0;
  assign r_live_resp = slot_rhit_i ? AXI_RESP_OKAY : AXI_RESP_SLVERR;

  // hold registers keep the response steady under back-pressure
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      slot_raddr_o <= axi_req_i.araddr[REG_LSB +: LOG2_NUM_REG];
    end
    if ((r_state == CH_EXEC) && !slot_re_o) begin
      r_data_q <= stats_i;
      r_resp_q <= AXI_RESP_OKAY;
    end
    if (r_from_slot_q) begin
      r_data_q <= r_live_data;
      r_resp_q <= r_live_resp;
    end
  end

  always_comb begin
    axi_rsp_o.awready = (w_state == CH_IDLE);
    axi_rsp_o.wready  = (w_state == CH_IDLE);
    axi_rsp_o.bvalid  = (w_state == CH_RESP);
    axi_rsp_o.bresp   = b_resp_q;
    axi_rsp_o.arready = (r_state == CH_IDLE);
    axi_rsp_o.rvalid  = (r_state == CH_RESP);
    axi_rsp_o.rdata   = r_from_slot_q ? r_live_data : r_data_q;
    axi_rsp_o.rresp   = r_from_slot_q ? r_live_resp : r_resp_q;
  end

endmodule

// ==== source/xbuf_exchange_top.sv ====
`timescale 1ns/1ps

module xbuf_exchange_top #(
  parameter int unsigned IDX_BITS = 2
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  xbuf_axi_pkg::axi_lite_req_t axi_req_i,
  output xbuf_axi_pkg::axi_lite_rsp_t axi_rsp_o
);
  import exec_unit_dtypes::*;

  logic               slot_we;
  type_exec_unit_addr slot_waddr;
  type_exec_unit_data slot_wdata;
  logic               slot_re;
  type_exec_unit_addr slot_raddr;
  logic               slot_wready;
  logic               slot_rhit;
  type_exec_unit_data slot_rdata;
  type_xbuf_event     xbuf_event;
  type_xbuf_stats     xbuf_stats_word;

  xbuf_ctrl u_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .axi_req_i     (axi_req_i),
    .axi_rsp_o     (axi_rsp_o),
    .slot_we_o     (slot_we),
    .slot_waddr_o  (slot_waddr),
    .slot_wdata_o  (slot_wdata),
    .slot_re_o     (slot_re),
    .slot_raddr_o  (slot_raddr),
    .slot_wready_i (slot_wready),
    .slot_rhit_i   (slot_rhit),
    .slot_rdata_i  (slot_rdata),
    .stats_i       (xbuf_stats_word)
  );

  xbuf_slot #(
    .IDX_BITS(IDX_BITS)
  ) u_slot (
    .clk      (clk),
    .reset_n  (reset_n),
    .we_i     (slot_we),
    .waddr_i  (slot_waddr),
    .wdata_i  (slot_wdata),
    .re_i     (slot_re),
    .raddr_i  (slot_raddr),
    .wready_o (slot_wready),
    .rhit_o   (slot_rhit),
    .rdata_o  (slot_rdata),
    .event_o  (xbuf_event)
  );

  xbuf_stats u_stats (
    .clk     (clk),
    .reset_n (reset_n),
    .event_i (xbuf_event),
    .stats_o (xbuf_stats_word)
  );

endmodule

// ==== dv/xbuf_tb_tasks.svh ====
// one AW/W transfer that returns once the B response has been seen
task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                         input logic [AXI_DATA_WIDTH-1:0] data,
                         output axi_resp_e resp);
  req.awvalid = 1'b1;
  req.wvalid  = 1'b1;
  req.awaddr  = addr;
  req.wdata   = data;
  while (!(rsp.awready && rsp.wready)) @(negedge clk);
  @(negedge clk);
  req.awvalid = 1'b0;
  req.wvalid  = 1'b0;
  while (!rsp.bvalid) @(negedge clk);
  resp = rsp.bresp;
  @(negedge clk);
endtask

// one AR transfer that leaves the response pending while rready is low
task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                        output logic [AXI_DATA_WIDTH-1:0] data,
                        output axi_resp_e resp);
  req.arvalid = 1'b1;
  req.araddr  = addr;
  while (!rsp.arready) @(negedge clk);
  @(negedge clk);
  req.arvalid = 1'b0;
  while (!rsp.rvalid) @(negedge clk);
  data = rsp.rdata;
  resp = rsp.rresp;
  @(negedge clk);
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  checks++;
  assert (got === exp)
  else begin
    errors++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
  end
endtask

task automatic flag_failure(input string what);
  errors++;
  $display("failure at %0t ns: %s", $time, what);
endtask

task automatic close_test(input string name);
  tests_done++;
  $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
           errors - errors_mark);
  checks_mark = checks;
  errors_mark = errors;
endtask

// ==== dv/xbuf_exchange_tb.sv ====
`timescale 1ns/1ps

module xbuf_exchange_tb;
  import exec_unit_dtypes::*;
  import xbuf_axi_pkg::*;

  localparam int IDX_BITS   = 2;
  localparam int SLOTS      = 2**IDX_BITS;
  localparam int CLK_PERIOD = 8;
  localparam int RAND_OPS   = 200;
  // reset plus at most 4 cycles per transaction and the held cycles
  localparam int RUN_CYCLES = 16 + 4 * (3 + 5 + 3 + 2 + RAND_OPS + 2 + 4) + 10;

  // expected content of one slot
  typedef struct packed {
    logic               valid;
    type_exec_unit_addr regn;
    type_exec_unit_data data;
    logic               has_been_read;
  } model_entry_t;

  logic          clk;
  logic          reset_n;
  axi_lite_req_t req;
  axi_lite_rsp_t rsp;

  model_entry_t   mdl [SLOTS];
  type_xbuf_stats exp_stats;
  int errors      = 0;
  int checks      = 0;
  int errors_mark = 0;
  int checks_mark = 0;
  int tests_done  = 0;

  xbuf_exchange_top #(
    .IDX_BITS(IDX_BITS)
  ) UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .axi_req_i (req),
    .axi_rsp_o (rsp)
  );

  `include "xbuf_tb_tasks.svh"

  // responses follow their handshake by exactly two cycles
  assert property (@(posedge clk) disable iff (!reset_n)
    req.awvalid && rsp.awready && req.wvalid && rsp.wready |=> !rsp.bvalid ##1 rsp.bvalid)
  else flag_failure("bvalid did not come two cycles after the write handshake");

  assert property (@(posedge clk) disable iff (!reset_n)
    req.arvalid && rsp.arready |=> !rsp.rvalid ##1 rsp.rvalid)
  else flag_failure("rvalid did not come two cycles after the read handshake");

  assert property (@(posedge clk) disable iff (!reset_n)
    rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
  else flag_failure("write response changed while bready was low");

  assert property (@(posedge clk) disable iff (!reset_n)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
  else flag_failure("read response changed while rready was low");

  // a channel with a pending response takes no new request
  assert property (@(posedge clk) disable iff (!reset_n)
    rsp.bvalid |-> !rsp.awready && !rsp.wready)
  else flag_failure("write channel was ready while a response was pending");

  assert property (@(posedge clk) disable iff (!reset_n) rsp.rvalid |-> !rsp.arready)
  else flag_failure("read channel was ready while a response was pending");

  function automatic logic [7:0] sat_up(input logic [7:0] cnt);
    return (cnt == 8'hff) ? cnt : cnt + 8'd1;
  endfunction

  // a write lands only in a slot whose last value was collected
  task automatic model_write(input type_exec_unit_addr r, input type_exec_unit_data d,
                             output axi_resp_e resp);
    logic [IDX_BITS-1:0] i;
    i = r[IDX_BITS-1:0];
    if (mdl[i].has_been_read) begin
      mdl[i] = '{valid: 1'b1, regn: r, data: d, has_been_read: 1'b0};
      resp = AXI_RESP_OKAY;
      exp_stats.write_ok = sat_up(exp_stats.write_ok);
    end else begin
      resp = AXI_RESP_SLVERR;
      exp_stats.write_reject = sat_up(exp_stats.write_reject);
    end
  endtask

  task automatic model_read(input type_exec_unit_addr r, output type_exec_unit_data data,
                            output axi_resp_e resp);
    logic [IDX_BITS-1:0] i;
    i = r[IDX_BITS-1:0];
    if (mdl[i].valid && (mdl[i].regn == r) && !mdl[i].has_been_read) begin
      mdl[i].has_been_read = 1'b1;
      data = mdl[i].data;
      resp = AXI_RESP_OKAY;
      exp_stats.read_hit = sat_up(exp_stats.read_hit);
    end else begin
      data = '0;
      resp = AXI_RESP_SLVERR;
      exp_stats.read_miss = sat_up(exp_stats.read_miss);
    end
  endtask

  task automatic do_write(input type_exec_unit_addr r, input type_exec_unit_data d);
    axi_resp_e exp_resp;
    axi_resp_e got_resp;
    model_write(r, d, exp_resp);
    axi_write({2'b00, r, 2'b00}, d, got_resp);
    check_value("bresp", got_resp, exp_resp);
  endtask

  task automatic do_read(input type_exec_unit_addr r);
    type_exec_unit_data exp_data;
    type_exec_unit_data got_data;
    axi_resp_e          exp_resp;
    axi_resp_e          got_resp;
    model_read(r, exp_data, exp_resp);
    axi_read({2'b00, r, 2'b00}, got_data, got_resp);
    check_value("rresp", got_resp, exp_resp);
    check_value("rdata", got_data, exp_data);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD * 3 / 2);
    $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES * 3 / 2);
    $display("Something failed");
    $finish;
  end

  initial begin
    type_exec_unit_data d;
    type_exec_unit_data rd_data;
    axi_resp_e          wr_resp;
    axi_resp_e          rd_resp;
    int unsigned        seed;
    seed = $urandom(28);
    foreach (mdl[i]) begin
      mdl[i] = '{valid: 1'b0, regn: '0, data: '0, has_been_read: 1'b1};
    end
    exp_stats  = '0;
    req        = '0;
    req.bready = 1'b1;
    req.rready = 1'b1;
    reset_n    = 1'b0;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_value("ready after reset", {rsp.awready, rsp.wready, rsp.arready, rsp.bvalid,
                rsp.rvalid}, 5'b11100);

    d = $urandom;
    do_write(4'd5, d);
    do_read(4'd5);
    do_read(4'd5);
    close_test("post_collect");

    do_write(4'd6, $urandom);
    do_write(4'd6, $urandom);
    do_read(4'd6);
    do_write(4'd6, $urandom);
    do_read(4'd6);
    close_test("occupied_slot");

    // registers 3 and 7 share slot 3
    do_write(4'd3, $urandom);
    do_read(4'd7);
    do_read(4'd3);
    close_test("tag_mismatch");

    // both handshakes land on the same edge so the store is left alone
    d = $urandom;
    fork
      axi_write(8'h24, d, wr_resp);
      axi_read(8'h24, rd_data, rd_resp);
    join
    exp_stats.write_ok = sat_up(exp_stats.write_ok);
    exp_stats.read_hit = sat_up(exp_stats.read_hit);
    check_value("bresp", wr_resp, AXI_RESP_OKAY);
    check_value("rresp", rd_resp, AXI_RESP_OKAY);
    check_value("rdata", rd_data, d);
    do_read(4'd9);
    close_test("collision");

    for (int n = 0; n < RAND_OPS; n++) begin
      if ($urandom_range(1) == 1) begin
        do_write(type_exec_unit_addr'($urandom_range(15)), $urandom);
      end else begin
        do_read(type_exec_unit_addr'($urandom_range(15)));
      end
    end
    axi_read(STATS_ADDR, rd_data, rd_resp);
    check_value("stats rresp", rd_resp, AXI_RESP_OKAY);
    check_value("stats rdata", rd_data, exp_stats);
    axi_write(STATS_ADDR, $urandom, wr_resp);
    check_value("stats bresp", wr_resp, AXI_RESP_SLVERR);
    close_test("statistics");

    // empty slot 2 first so the held read below is a hit
    if (!mdl[2].has_been_read) begin
      do_read(mdl[2].regn);
    end
    // second request stays offered while the first response is held
    do_write(4'd2, $urandom);
    req.rready = 1'b0;
    do_read(4'd2);
    req.arvalid = 1'b1;
    repeat (4) @(negedge clk);
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    @(negedge clk);
    req.bready = 1'b0;
    do_write(4'd2, $urandom);
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    repeat (4) @(negedge clk);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.bready  = 1'b1;
    @(negedge clk);
    close_test("back_pressure");

    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== xbuf_exchange.f ====
+incdir+dv
source/exec_unit_dtypes.sv
source/xbuf_axi_pkg.sv
source/xbuf_tag_store.sv
source/xbuf_slot.sv
source/xbuf_stats.sv
source/xbuf_ctrl.sv
source/xbuf_exchange_top.sv
dv/xbuf_exchange_tb.sv
